//--- all.f
+incdir+verification
src/rename_arch_pkg.sv
src/rename_operand_pkg.sv
src/rename_alloc_ctrl.sv
src/rename_map_table.sv
src/rename_source_select.sv
src/rename_stage_reg.sv
src/rename_top.sv
verification/tb_clock_gen.sv
verification/rename_tb.sv

//--- verification/rename_vectors.svh
//////////////////////////////////////////////////////////////
// Stimulus table of the rename testbench, one row per clock
// Each row holds behavior, slot inputs, controls, commits and expected outputs
//////////////////////////////////////////////////////////////
`ifndef RENAME_VECTORS_SVH
`define RENAME_VECTORS_SVH

// One decoded instruction with the free name offered to its slot
typedef struct packed {
	logic valid;
	logic wb;
	lreg_t dest;
	lreg_t src0;
	logic imm;
	logic [31:0] src1;
	preg_t num;
} slot_in_t;

typedef struct packed {
	logic valid;
	lreg_t lreg;
	preg_t preg;
} retire_t;

// What the next stage should see one cycle after the row
typedef struct packed {
	logic valid;
	preg_t dest;
	preg_t src0;
	logic [31:0] src1;
} slot_exp_t;

// ctl is {free_0_empty, free_1_empty, next_lock, flush, restart}
// want is {prev_lock, free_0_rd, free_1_rd} in the same cycle
typedef struct packed {
	int beh;
	slot_in_t in0;
	slot_in_t in1;
	logic [4:0] ctl;
	retire_t c0;
	retire_t c1;
	logic [2:0] want;
	slot_exp_t out0;
	slot_exp_t out1;
} vec_row_t;

vec_row_t rows [$];

function automatic slot_in_t reg_op(input logic wb, input lreg_t dest, input lreg_t src0,
		input lreg_t src1, input preg_t num);
	return '{1'b1, wb, dest, src0, 1'b0, {27'b0, src1}, num};
endfunction

function automatic slot_in_t imm_op(input logic wb, input lreg_t dest, input lreg_t src0,
		input logic [31:0] word, input preg_t num);
	return '{1'b1, wb, dest, src0, 1'b1, word, num};
endfunction

function automatic retire_t retire(input lreg_t lreg, input preg_t preg);
	return '{1'b1, lreg, preg};
endfunction

function automatic slot_exp_t exp_op(input preg_t dest, input preg_t src0,
		input logic [31:0] src1);
	return '{1'b1, dest, src0, src1};
endfunction

task automatic add_row(input int beh, input slot_in_t in0, input slot_in_t in1,
		input logic [4:0] ctl, input retire_t c0, input retire_t c1, input logic [2:0] want,
		input slot_exp_t out0, input slot_exp_t out1);
	rows.push_back('{beh, in0, in1, ctl, c0, c1, want, out0, out1});
endtask

task automatic load_vectors();
	// Identity map
	add_row(1, '0, '0, 5'b00000, '0, '0, 3'b000, '0, '0);
	add_row(1, reg_op(0, 0, 3, 7, 0), reg_op(0, 0, 7, 3, 0), 5'b00000, '0, '0, 3'b000,
		exp_op(0, 3, 7), exp_op(0, 7, 3));
	// Allocation, later reads and same destination in both slots
	add_row(2, reg_op(1, 4, 1, 2, 33), reg_op(1, 6, 8, 9, 34), 5'b00000, '0, '0, 3'b011,
		exp_op(33, 1, 2), exp_op(34, 8, 9));
	add_row(2, reg_op(0, 0, 4, 6, 36), reg_op(1, 10, 6, 4, 35), 5'b00000, '0, '0, 3'b001,
		exp_op(0, 33, 34), exp_op(35, 34, 33));
	add_row(2, reg_op(1, 12, 10, 0, 36), reg_op(1, 12, 0, 10, 37), 5'b00000, '0, '0, 3'b011,
		exp_op(36, 35, 0), exp_op(37, 0, 35));
	add_row(2, reg_op(0, 0, 12, 12, 0), reg_op(0, 0, 4, 6, 0), 5'b00000, '0, '0, 3'b000,
		exp_op(0, 37, 37), exp_op(0, 33, 34));
	// In-pair bypass and immediates left as they are
	add_row(3, reg_op(1, 14, 1, 2, 38), reg_op(1, 15, 14, 14, 39), 5'b00000, '0, '0, 3'b011,
		exp_op(38, 1, 2), exp_op(39, 38, 38));
	add_row(3, imm_op(1, 3, 14, 32'hDEAD_BEEF, 40), imm_op(0, 0, 15, 32'h1234_5603, 41),
		5'b00000, '0, '0, 3'b010, exp_op(40, 38, 32'hDEAD_BEEF), exp_op(0, 39, 32'h1234_5603));
	// Stall on each empty free list and on next_lock while the stage holds the older pair
	add_row(4, reg_op(0, 0, 3, 1, 0), reg_op(0, 0, 14, 15, 0), 5'b00000, '0, '0, 3'b000,
		'0, '0);
	add_row(4, reg_op(1, 5, 3, 1, 41), reg_op(1, 6, 5, 6, 42), 5'b10000, '0, '0, 3'b100,
		'0, '0);
	add_row(4, reg_op(1, 5, 3, 1, 41), reg_op(1, 6, 5, 6, 42), 5'b01000, '0, '0, 3'b100,
		'0, '0);
	add_row(4, reg_op(1, 5, 3, 1, 41), reg_op(1, 6, 5, 6, 42), 5'b00100, '0, '0, 3'b100,
		exp_op(0, 40, 1), exp_op(0, 38, 39));
	add_row(4, reg_op(0, 0, 5, 6, 0), reg_op(0, 0, 4, 3, 0), 5'b00000, '0, '0, 3'b000,
		exp_op(0, 5, 34), exp_op(0, 33, 40));
	// Flush, commits and restart
	add_row(5, reg_op(0, 0, 1, 2, 0), reg_op(0, 0, 1, 2, 0), 5'b00010, '0, '0, 3'b000,
		'0, '0);
	add_row(5, reg_op(1, 2, 0, 0, 43), reg_op(1, 7, 2, 5, 44), 5'b00000, retire(2, 40),
		retire(5, 41), 3'b011, exp_op(43, 0, 0), exp_op(44, 43, 5));
	add_row(5, reg_op(0, 0, 2, 7, 0), reg_op(0, 0, 5, 4, 0), 5'b00000, '0, '0, 3'b000,
		exp_op(0, 43, 44), exp_op(0, 5, 33));
	add_row(5, reg_op(1, 9, 0, 0, 45), '0, 5'b00001, '0, '0, 3'b010, exp_op(45, 0, 0), '0);
	add_row(5, reg_op(0, 0, 2, 5, 0), reg_op(0, 0, 4, 9, 0), 5'b00000, '0, '0, 3'b000,
		exp_op(0, 40, 41), exp_op(0, 4, 9));
	add_row(5, '0, '0, 5'b00000, '0, '0, 3'b000, '0, '0);
endtask

`endif

//--- verification/rename_tb.sv
//////////////////////////////////////////////////////////////
// Testbench of the two-wide rename stage
// Applies the vector table row by row and checks each response
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rename_tb;
	import rename_arch_pkg::*;
	import rename_operand_pkg::*;

	`include "rename_vectors.svh"

	localparam int RESET_CYCLES = 10;

	logic iCLOCK;
	logic inRESET;
	logic flush;
	logic restart;
	logic prev_0_valid;
	logic prev_0_writeback;
	cmd_t prev_0_cmd;
	lreg_t prev_0_dest;
	lreg_t prev_0_src0;
	operand_u prev_0_src1;
	logic prev_0_src1_imm;
	logic prev_1_valid;
	logic prev_1_writeback;
	cmd_t prev_1_cmd;
	lreg_t prev_1_dest;
	lreg_t prev_1_src0;
	operand_u prev_1_src1;
	logic prev_1_src1_imm;
	logic prev_lock;
	preg_t free_0_num;
	logic free_0_empty;
	logic free_0_rd;
	preg_t free_1_num;
	logic free_1_empty;
	logic free_1_rd;
	logic next_0_valid;
	logic next_0_writeback;
	cmd_t next_0_cmd;
	lreg_t next_0_dest_lreg;
	preg_t next_0_dest_preg;
	preg_t next_0_src0;
	operand_u next_0_src1;
	logic next_0_src1_imm;
	logic next_1_valid;
	logic next_1_writeback;
	cmd_t next_1_cmd;
	lreg_t next_1_dest_lreg;
	preg_t next_1_dest_preg;
	preg_t next_1_src0;
	operand_u next_1_src1;
	logic next_1_src1_imm;
	logic next_lock;
	logic commit_0_valid;
	lreg_t commit_0_lreg;
	preg_t commit_0_preg;
	logic commit_1_valid;
	lreg_t commit_1_lreg;
	preg_t commit_1_preg;

	int pass_count = 0;
	int fail_count = 0;
	int beh_fails [1:5];
	int cycle_count = 0;
	int cycle_limit;
	// Row whose pair sits in the stage register
	int stage_row = 0;
	string beh_name [1:5] = '{"identity map after reset", "allocation and map update",
		"slot 1 bypass and immediates", "lock and hold", "flush, commit and restart"};

	tb_clock_gen u_clk (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET)
	);

	rename_top u_dut (.*);

	task automatic check_value(input string field, input int beh, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) pass_count++;
		else begin
			$display("MISMATCH at %0t: %s got %0h expected %0h", $time, field, got, exp);
			fail_count++;
			beh_fails[beh]++;
		end
	endtask

	// Opcode tag that marks each slot of each row
	function automatic cmd_t slot_cmd(input int idx, input int slot);
		return cmd_t'(2 * idx + slot);
	endfunction

	task automatic drive_row(input vec_row_t r, input int idx);
		prev_0_valid = r.in0.valid;
		prev_0_writeback = r.in0.wb;
		prev_0_cmd = slot_cmd(idx, 0);
		prev_0_dest = r.in0.dest;
		prev_0_src0 = r.in0.src0;
		prev_0_src1 = r.in0.src1;
		prev_0_src1_imm = r.in0.imm;
		free_0_num = r.in0.num;
		prev_1_valid = r.in1.valid;
		prev_1_writeback = r.in1.wb;
		prev_1_cmd = slot_cmd(idx, 1);
		prev_1_dest = r.in1.dest;
		prev_1_src0 = r.in1.src0;
		prev_1_src1 = r.in1.src1;
		prev_1_src1_imm = r.in1.imm;
		free_1_num = r.in1.num;
		{free_0_empty, free_1_empty, next_lock, flush, restart} = r.ctl;
		commit_0_valid = r.c0.valid;
		commit_0_lreg = r.c0.lreg;
		commit_0_preg = r.c0.preg;
		commit_1_valid = r.c1.valid;
		commit_1_lreg = r.c1.lreg;
		commit_1_preg = r.c1.preg;
	endtask

	// Same-cycle stall and pop strobes
	task automatic check_now(input vec_row_t r);
		check_value("prev_lock", r.beh, 32'(prev_lock), 32'(r.want[2]));
		check_value("free_0_rd", r.beh, 32'(free_0_rd), 32'(r.want[1]));
		check_value("free_1_rd", r.beh, 32'(free_1_rd), 32'(r.want[0]));
	endtask

	// Registered pair with payload checked only under its valid bit
	task automatic check_next(input vec_row_t r, input int src);
		check_value("next_0_valid", r.beh, 32'(next_0_valid), 32'(r.out0.valid));
		check_value("next_1_valid", r.beh, 32'(next_1_valid), 32'(r.out1.valid));
		if (r.out0.valid) begin
			check_value("next_0_dest_preg", r.beh, 32'(next_0_dest_preg), 32'(r.out0.dest));
			check_value("next_0_src0", r.beh, 32'(next_0_src0), 32'(r.out0.src0));
			check_value("next_0_src1", r.beh, next_0_src1.imm, r.out0.src1);
			check_value("next_0_writeback", r.beh, 32'(next_0_writeback),
				32'(rows[src].in0.wb));
			check_value("next_0_cmd", r.beh, 32'(next_0_cmd), 32'(slot_cmd(src, 0)));
			check_value("next_0_dest_lreg", r.beh, 32'(next_0_dest_lreg),
				32'(rows[src].in0.dest));
			check_value("next_0_src1_imm", r.beh, 32'(next_0_src1_imm),
				32'(rows[src].in0.imm));
		end
		if (r.out1.valid) begin
			check_value("next_1_dest_preg", r.beh, 32'(next_1_dest_preg), 32'(r.out1.dest));
			check_value("next_1_src0", r.beh, 32'(next_1_src0), 32'(r.out1.src0));
			check_value("next_1_src1", r.beh, next_1_src1.imm, r.out1.src1);
			check_value("next_1_writeback", r.beh, 32'(next_1_writeback),
				32'(rows[src].in1.wb));
			check_value("next_1_cmd", r.beh, 32'(next_1_cmd), 32'(slot_cmd(src, 1)));
			check_value("next_1_dest_lreg", r.beh, 32'(next_1_dest_lreg),
				32'(rows[src].in1.dest));
			check_value("next_1_src1_imm", r.beh, 32'(next_1_src1_imm),
				32'(rows[src].in1.imm));
		end
	endtask

	task automatic report_behavior(input int beh);
		if (beh_fails[beh] == 0) begin
			$display("behavior %0d (%s) ok", beh, beh_name[beh]);
		end else begin
			$display("behavior %0d (%s) %0d errors", beh, beh_name[beh], beh_fails[beh]);
		end
	endtask

	initial begin
		drive_row('0, 0);
		load_vectors();
		cycle_limit = RESET_CYCLES + 2 * rows.size() + 20;
		wait (inRESET === 1'b1);
		#1;
		check_value("next_0_valid after reset", 1, 32'(next_0_valid), 32'd0);
		check_value("next_1_valid after reset", 1, 32'(next_1_valid), 32'd0);
		// Drive 1 ns after the edge and sample mid-cycle
		for (int i = 0; i < rows.size(); i++) begin
			@(posedge iCLOCK);
			#1;
			drive_row(rows[i], i);
			#4;
			check_now(rows[i]);
			if (i > 0) begin
				check_next(rows[i-1], stage_row);
				if (rows[i-1].beh != rows[i].beh) begin
					report_behavior(rows[i-1].beh);
				end
			end
			// No empty free list and no next_lock, so the stage takes this pair
			if (rows[i].ctl[4:2] == 3'b000) begin
				stage_row = i;
			end
		end
		report_behavior(rows[rows.size()-1].beh);
		$display("checks passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// Guard against a stuck run
	always @(posedge iCLOCK) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Timeout after %0d clock cycles, the vector table did not finish",
				cycle_count);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

endmodule

//--- verification/tb_clock_gen.sv
//////////////////////////////////////////////////////////////
// Clock and reset source for the rename testbench
// 10 ns clock, reset held low for the first 10 rising edges
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_clock_gen (
	output logic iCLOCK,
	output logic inRESET
);
	localparam int HALF_PERIOD = 5;
	localparam int RESET_CYCLES = 10;

	initial begin
		iCLOCK = 1'b0;
		forever #HALF_PERIOD iCLOCK = ~iCLOCK;
	end

	// Release just after an edge so it never races the DUT flops
	initial begin
		inRESET = 1'b0;
		repeat (RESET_CYCLES) @(posedge iCLOCK);
		#1;
		inRESET = 1'b1;
	end

endmodule

//--- src/rename_top.sv
//////////////////////////////////////////////////////////////
// Two-wide register rename stage
// Sits between decode and dispatch, fed by two external free lists
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rename_top (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic restart,
	// From decode
	input logic prev_0_valid,
	input logic prev_0_writeback,
	input rename_operand_pkg::cmd_t prev_0_cmd,
	input rename_arch_pkg::lreg_t prev_0_dest,
	input rename_arch_pkg::lreg_t prev_0_src0,
	input rename_operand_pkg::operand_u prev_0_src1,
	input logic prev_0_src1_imm,
	input logic prev_1_valid,
	input logic prev_1_writeback,
	input rename_operand_pkg::cmd_t prev_1_cmd,
	input rename_arch_pkg::lreg_t prev_1_dest,
	input rename_arch_pkg::lreg_t prev_1_src0,
	input rename_operand_pkg::operand_u prev_1_src1,
	input logic prev_1_src1_imm,
	output logic prev_lock,
	// Free lists
	input rename_arch_pkg::preg_t free_0_num,
	input logic free_0_empty,
	output logic free_0_rd,
	input rename_arch_pkg::preg_t free_1_num,
	input logic free_1_empty,
	output logic free_1_rd,
	// To next stage
	output logic next_0_valid,
	output logic next_0_writeback,
	output rename_operand_pkg::cmd_t next_0_cmd,
	output rename_arch_pkg::lreg_t next_0_dest_lreg,
	output rename_arch_pkg::preg_t next_0_dest_preg,
	output rename_arch_pkg::preg_t next_0_src0,
	output rename_operand_pkg::operand_u next_0_src1,
	output logic next_0_src1_imm,
	output logic next_1_valid,
	output logic next_1_writeback,
	output rename_operand_pkg::cmd_t next_1_cmd,
	output rename_arch_pkg::lreg_t next_1_dest_lreg,
	output rename_arch_pkg::preg_t next_1_dest_preg,
	output rename_arch_pkg::preg_t next_1_src0,
	output rename_operand_pkg::operand_u next_1_src1,
	output logic next_1_src1_imm,
	input logic next_lock,
	// Retire side
	input logic commit_0_valid,
	input rename_arch_pkg::lreg_t commit_0_lreg,
	input rename_arch_pkg::preg_t commit_0_preg,
	input logic commit_1_valid,
	input rename_arch_pkg::lreg_t commit_1_lreg,
	input rename_arch_pkg::preg_t commit_1_preg
);
	import rename_arch_pkg::*;
	import rename_operand_pkg::*;

	logic lock;
	logic map_we_0;
	logic map_we_1;
	lreg_t read_a_lreg;
	lreg_t read_b_lreg;
	lreg_t read_c_lreg;
	lreg_t read_d_lreg;
	preg_t read_a_preg;
	preg_t read_b_preg;
	preg_t read_c_preg;
	preg_t read_d_preg;
	preg_t ren_0_src0;
	preg_t ren_1_src0;
	operand_u ren_0_src1;
	operand_u ren_1_src1;

	rename_alloc_ctrl u_alloc (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.prev_0_valid(prev_0_valid),
		.prev_0_writeback(prev_0_writeback),
		.prev_1_valid(prev_1_valid),
		.prev_1_writeback(prev_1_writeback),
		.free_0_empty(free_0_empty),
		.free_1_empty(free_1_empty),
		.next_lock(next_lock),
		.lock(lock),
		.prev_lock(prev_lock),
		.free_0_rd(free_0_rd),
		.free_1_rd(free_1_rd),
		.map_we_0(map_we_0),
		.map_we_1(map_we_1)
	);

	rename_map_table u_map (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.restart(restart),
		.map_we_0(map_we_0),
		.map_we_1(map_we_1),
		.prev_0_dest(prev_0_dest),
		.prev_1_dest(prev_1_dest),
		.free_0_num(free_0_num),
		.free_1_num(free_1_num),
		.commit_0_valid(commit_0_valid),
		.commit_0_lreg(commit_0_lreg),
		.commit_0_preg(commit_0_preg),
		.commit_1_valid(commit_1_valid),
		.commit_1_lreg(commit_1_lreg),
		.commit_1_preg(commit_1_preg),
		.read_a_lreg(read_a_lreg),
		.read_b_lreg(read_b_lreg),
		.read_c_lreg(read_c_lreg),
		.read_d_lreg(read_d_lreg),
		.read_a_preg(read_a_preg),
		.read_b_preg(read_b_preg),
		.read_c_preg(read_c_preg),
		.read_d_preg(read_d_preg)
	);

	rename_source_select u_src (
		.prev_0_src0(prev_0_src0),
		.prev_0_src1(prev_0_src1),
		.prev_0_src1_imm(prev_0_src1_imm),
		.prev_1_src0(prev_1_src0),
		.prev_1_src1(prev_1_src1),
		.prev_1_src1_imm(prev_1_src1_imm),
		.prev_0_dest(prev_0_dest),
		.map_we_0(map_we_0),
		.free_0_num(free_0_num),
		.read_a_preg(read_a_preg),
		.read_b_preg(read_b_preg),
		.read_c_preg(read_c_preg),
		.read_d_preg(read_d_preg),
		.read_a_lreg(read_a_lreg),
		.read_b_lreg(read_b_lreg),
		.read_c_lreg(read_c_lreg),
		.read_d_lreg(read_d_lreg),
		.ren_0_src0(ren_0_src0),
		.ren_0_src1(ren_0_src1),
		.ren_1_src0(ren_1_src0),
		.ren_1_src1(ren_1_src1)
	);

	rename_stage_reg u_stage (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.lock(lock),
		.flush(flush),
		.prev_0_valid(prev_0_valid),
		.prev_0_writeback(prev_0_writeback),
		.prev_0_cmd(prev_0_cmd),
		.prev_0_dest(prev_0_dest),
		.prev_0_src1_imm(prev_0_src1_imm),
		.ren_0_src0(ren_0_src0),
		.ren_0_src1(ren_0_src1),
		.free_0_num(free_0_num),
		.prev_1_valid(prev_1_valid),
		.prev_1_writeback(prev_1_writeback),
		.prev_1_cmd(prev_1_cmd),
		.prev_1_dest(prev_1_dest),
		.prev_1_src1_imm(prev_1_src1_imm),
		.ren_1_src0(ren_1_src0),
		.ren_1_src1(ren_1_src1),
		.free_1_num(free_1_num),
		.next_0_valid(next_0_valid),
		.next_0_writeback(next_0_writeback),
		.next_0_cmd(next_0_cmd),
		.next_0_dest_lreg(next_0_dest_lreg),
		.next_0_dest_preg(next_0_dest_preg),
		.next_0_src0(next_0_src0),
		.next_0_src1(next_0_src1),
		.next_0_src1_imm(next_0_src1_imm),
		.next_1_valid(next_1_valid),
		.next_1_writeback(next_1_writeback),
		.next_1_cmd(next_1_cmd),
		.next_1_dest_lreg(next_1_dest_lreg),
		.next_1_dest_preg(next_1_dest_preg),
		.next_1_src0(next_1_src0),
		.next_1_src1(next_1_src1),
		.next_1_src1_imm(next_1_src1_imm)
	);

endmodule

//--- src/rename_stage_reg.sv
//////////////////////////////////////////////////////////////
// Output register of the renamed instruction pair
// Holds while locked and flush drops both valid bits
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rename_stage_reg (
	input logic iCLOCK,
	input logic inRESET,
	input logic lock,
	input logic flush,
	// Slot 0
	input logic prev_0_valid,
	input logic prev_0_writeback,
	input rename_operand_pkg::cmd_t prev_0_cmd,
	input rename_arch_pkg::lreg_t prev_0_dest,
	input logic prev_0_src1_imm,
	input rename_arch_pkg::preg_t ren_0_src0,
	input rename_operand_pkg::operand_u ren_0_src1,
	input rename_arch_pkg::preg_t free_0_num,
	// Slot 1
	input logic prev_1_valid,
	input logic prev_1_writeback,
	input rename_operand_pkg::cmd_t prev_1_cmd,
	input rename_arch_pkg::lreg_t prev_1_dest,
	input logic prev_1_src1_imm,
	input rename_arch_pkg::preg_t ren_1_src0,
	input rename_operand_pkg::operand_u ren_1_src1,
	input rename_arch_pkg::preg_t free_1_num,
	// To next stage
	output logic next_0_valid,
	output logic next_0_writeback,
	output rename_operand_pkg::cmd_t next_0_cmd,
	output rename_arch_pkg::lreg_t next_0_dest_lreg,
	output rename_arch_pkg::preg_t next_0_dest_preg,
	output rename_arch_pkg::preg_t next_0_src0,
	output rename_operand_pkg::operand_u next_0_src1,
	output logic next_0_src1_imm,
	output logic next_1_valid,
	output logic next_1_writeback,
	output rename_operand_pkg::cmd_t next_1_cmd,
	output rename_arch_pkg::lreg_t next_1_dest_lreg,
	output rename_arch_pkg::preg_t next_1_dest_preg,
	output rename_arch_pkg::preg_t next_1_src0,
	output rename_operand_pkg::operand_u next_1_src1,
	output logic next_1_src1_imm
);
	import rename_arch_pkg::*;
	import rename_operand_pkg::*;

	logic [1:0] valid_q;
	logic [1:0] writeback_q;
	cmd_t cmd_q [2];
	lreg_t dest_lreg_q [2];
	preg_t dest_preg_q [2];
	preg_t src0_q [2];
	operand_u src1_q [2];
	logic [1:0] src1_imm_q;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= '0;
			writeback_q <= '0;
		end else begin
			if (!lock) begin
				valid_q <= {prev_1_valid, prev_0_valid};
				writeback_q <= {prev_1_writeback, prev_0_writeback};
			end
			// Flush applies even when the stage is held
			if (flush) begin
				valid_q <= '0;
			end
		end
	end

	// Payload is meaningful only with its valid bit
	always_ff @(posedge iCLOCK) begin
		if (!lock) begin
			cmd_q <= '{prev_0_cmd, prev_1_cmd};
			dest_lreg_q <= '{prev_0_dest, prev_1_dest};
			dest_preg_q <= '{free_0_num, free_1_num};
			src0_q <= '{ren_0_src0, ren_1_src0};
			src1_q <= '{ren_0_src1, ren_1_src1};
			src1_imm_q <= {prev_1_src1_imm, prev_0_src1_imm};
		end
	end

	assign next_0_valid = valid_q[0] && !lock;
	assign next_0_writeback = writeback_q[0];
	assign next_0_cmd = cmd_q[0];
	assign next_0_dest_lreg = dest_lreg_q[0];
	assign next_0_dest_preg = writeback_q[0] ? dest_preg_q[0] : '0;
	assign next_0_src0 = src0_q[0];
	assign next_0_src1 = src1_q[0];
	assign next_0_src1_imm = src1_imm_q[0];

	assign next_1_valid = valid_q[1] && !lock;
	assign next_1_writeback = writeback_q[1];
	assign next_1_cmd = cmd_q[1];
	assign next_1_dest_lreg = dest_lreg_q[1];
	assign next_1_dest_preg = writeback_q[1] ? dest_preg_q[1] : '0;
	assign next_1_src0 = src0_q[1];
	assign next_1_src1 = src1_q[1];
	assign next_1_src1_imm = src1_imm_q[1];

endmodule

//--- src/rename_source_select.sv
//////////////////////////////////////////////////////////////
// Source operand translation for both slots
// Slot 1 picks up slot 0's new name when it reads slot 0's destination
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rename_source_select (
	input rename_arch_pkg::lreg_t prev_0_src0,
	input rename_operand_pkg::operand_u prev_0_src1,
	input logic prev_0_src1_imm,
	input rename_arch_pkg::lreg_t prev_1_src0,
	input rename_operand_pkg::operand_u prev_1_src1,
	input logic prev_1_src1_imm,
	input rename_arch_pkg::lreg_t prev_0_dest,
	input logic map_we_0,
	input rename_arch_pkg::preg_t free_0_num,
	input rename_arch_pkg::preg_t read_a_preg,
	input rename_arch_pkg::preg_t read_b_preg,
	input rename_arch_pkg::preg_t read_c_preg,
	input rename_arch_pkg::preg_t read_d_preg,
	output rename_arch_pkg::lreg_t read_a_lreg,
	output rename_arch_pkg::lreg_t read_b_lreg,
	output rename_arch_pkg::lreg_t read_c_lreg,
	output rename_arch_pkg::lreg_t read_d_lreg,
	output rename_arch_pkg::preg_t ren_0_src0,
	output rename_operand_pkg::operand_u ren_0_src1,
	output rename_arch_pkg::preg_t ren_1_src0,
	output rename_operand_pkg::operand_u ren_1_src1
);
	import rename_arch_pkg::*;
	import rename_operand_pkg::*;

	logic hit_1_src0;
	logic hit_1_src1;

	function automatic operand_u preg_word(input preg_t num);
		operand_u word;
		word.preg.pad = '0;
		word.preg.num = num;
		return word;
	endfunction

	// Lookup addresses, slot 0 on ports a/b and slot 1 on c/d
	assign read_a_lreg = prev_0_src0;
	assign read_b_lreg = prev_0_src1.lreg.num;
	assign read_c_lreg = prev_1_src0;
	assign read_d_lreg = prev_1_src1.lreg.num;

	// In-pair dependency on slot 0's destination
	assign hit_1_src0 = map_we_0 && (prev_1_src0 == prev_0_dest);
	assign hit_1_src1 = map_we_0 && !prev_1_src1_imm && (prev_1_src1.lreg.num == prev_0_dest);

	assign ren_0_src0 = read_a_preg;
	assign ren_1_src0 = hit_1_src0 ? free_0_num : read_c_preg;

	// Immediates go through as they are
	assign ren_0_src1 = prev_0_src1_imm ? prev_0_src1 : preg_word(read_b_preg);
	assign ren_1_src1 = prev_1_src1_imm ? prev_1_src1 :
		preg_word(hit_1_src1 ? free_0_num : read_d_preg);

endmodule

//--- src/rename_map_table.sv
//////////////////////////////////////////////////////////////
// Speculative and committed register maps with four read ports
// Rename writes the speculative map, retire writes the committed one
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rename_map_table (
	input logic iCLOCK,
	input logic inRESET,
	input logic restart,
	// Rename writes
	input logic map_we_0,
	input logic map_we_1,
	input rename_arch_pkg::lreg_t prev_0_dest,
	input rename_arch_pkg::lreg_t prev_1_dest,
	input rename_arch_pkg::preg_t free_0_num,
	input rename_arch_pkg::preg_t free_1_num,
	// Retire side
	input logic commit_0_valid,
	input rename_arch_pkg::lreg_t commit_0_lreg,
	input rename_arch_pkg::preg_t commit_0_preg,
	input logic commit_1_valid,
	input rename_arch_pkg::lreg_t commit_1_lreg,
	input rename_arch_pkg::preg_t commit_1_preg,
	// Source lookups
	input rename_arch_pkg::lreg_t read_a_lreg,
	input rename_arch_pkg::lreg_t read_b_lreg,
	input rename_arch_pkg::lreg_t read_c_lreg,
	input rename_arch_pkg::lreg_t read_d_lreg,
	output rename_arch_pkg::preg_t read_a_preg,
	output rename_arch_pkg::preg_t read_b_preg,
	output rename_arch_pkg::preg_t read_c_preg,
	output rename_arch_pkg::preg_t read_d_preg
);
	import rename_arch_pkg::*;

	preg_t spec_map [NUM_LREG];
	preg_t commit_map [NUM_LREG];

	// Speculative map, restart wins over rename writes
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < NUM_LREG; i++) begin
				spec_map[i] <= preg_t'(i);
			end
		end else if (restart) begin
			spec_map <= commit_map;
		end else begin
			if (map_we_0) begin
				spec_map[prev_0_dest] <= free_0_num;
			end
			// Younger slot lands last on a shared destination
			if (map_we_1) begin
				spec_map[prev_1_dest] <= free_1_num;
			end
		end
	end

	// Committed map
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < NUM_LREG; i++) begin
				commit_map[i] <= preg_t'(i);
			end
		end else begin
			if (commit_0_valid) begin
				commit_map[commit_0_lreg] <= commit_0_preg;
			end
			if (commit_1_valid) begin
				commit_map[commit_1_lreg] <= commit_1_preg;
			end
		end
	end

	// Lookups see the map before this edge
	assign read_a_preg = spec_map[read_a_lreg];
	assign read_b_preg = spec_map[read_b_lreg];
	assign read_c_preg = spec_map[read_c_lreg];
	assign read_d_preg = spec_map[read_d_lreg];

	// Retire never commits two names for one register in a cycle
	a_commit_distinct: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(commit_0_valid && commit_1_valid) |-> (commit_0_lreg != commit_1_lreg))
		else $error("commit ports name the same logical register");

endmodule

//--- src/rename_alloc_ctrl.sv
//////////////////////////////////////////////////////////////
// Stall and allocation control of the rename stage
// Pops the free lists and enables map writes for accepted slots
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rename_alloc_ctrl (
	input logic iCLOCK,
	input logic inRESET,
	input logic prev_0_valid,
	input logic prev_0_writeback,
	input logic prev_1_valid,
	input logic prev_1_writeback,
	input logic free_0_empty,
	input logic free_1_empty,
	input logic next_lock,
	output logic lock,
	output logic prev_lock,
	output logic free_0_rd,
	output logic free_1_rd,
	output logic map_we_0,
	output logic map_we_1
);

	// Either free list dry or next stage full
	assign lock = free_0_empty || free_1_empty || next_lock;
	assign prev_lock = lock;

	assign map_we_0 = prev_0_valid && prev_0_writeback && !lock;
	assign map_we_1 = prev_1_valid && prev_1_writeback && !lock;

	// One pop per renamed destination
	assign free_0_rd = map_we_0;
	assign free_1_rd = map_we_1;

endmodule

//--- src/rename_operand_pkg.sv
//////////////////////////////////////////////////////////////
// Opcode and second source word formats
// The source word is an immediate, or a register name before or after rename
//////////////////////////////////////////////////////////////
package rename_operand_pkg;

	localparam int WORD_WIDTH = 32;
	localparam int CMD_WIDTH = 5;

	typedef logic [CMD_WIDTH-1:0] cmd_t;

	// Register operand as decode delivers it
	typedef struct packed {
		logic [WORD_WIDTH-rename_arch_pkg::LREG_WIDTH-1:0] pad;
		rename_arch_pkg::lreg_t num;
	} src_lreg_t;

	// Register operand after translation
	typedef struct packed {
		logic [WORD_WIDTH-rename_arch_pkg::PREG_WIDTH-1:0] pad;
		rename_arch_pkg::preg_t num;
	} src_preg_t;

	// View picked by the immediate flag and by which side of rename the word is on
	typedef union packed {
		logic [WORD_WIDTH-1:0] imm;
		src_lreg_t lreg;
		src_preg_t preg;
	} operand_u;

endpackage

//--- src/rename_arch_pkg.sv
//////////////////////////////////////////////////////////////
// Architectural register names for the rename stage
// Logical names come from decode, physical names from the free lists
//////////////////////////////////////////////////////////////
package rename_arch_pkg;

	// Logical general registers
	localparam int LREG_WIDTH = 5;
	localparam int NUM_LREG = 32;

	// Physical register file, fixed by the free list format
	localparam int PREG_WIDTH = 6;

	typedef logic [LREG_WIDTH-1:0] lreg_t;
	typedef logic [PREG_WIDTH-1:0] preg_t;

endpackage
